/* src/rv_decode_pkg.sv */
package rv_decode_pkg;

    // field widths of a full 32-bit encoding
    localparam int WORD_BITS    = 32;
    localparam int REG_IDX_BITS = 5;
    localparam int FUNCT3_BITS  = 3;
    localparam int FUNCT7_BITS  = 7;
    localparam int OPC_BITS     = 5;
    localparam int CSR_IDX_BITS = 12;

    typedef logic [WORD_BITS-1:0]    word_t;
    typedef logic [REG_IDX_BITS-1:0] reg_idx_t;
    typedef logic [FUNCT3_BITS-1:0]  funct3_t;
    typedef logic [FUNCT7_BITS-1:0]  funct7_t;
    typedef logic [OPC_BITS-1:0]     opc_t;
    typedef logic [CSR_IDX_BITS-1:0] csr_idx_t;

    // major opcodes, instruction bits 6..2
    localparam opc_t OPC_LOAD   = 5'b00000;
    localparam opc_t OPC_OP_IMM = 5'b00100;
    localparam opc_t OPC_AUIPC  = 5'b00101;
    localparam opc_t OPC_STORE  = 5'b01000;
    localparam opc_t OPC_OP     = 5'b01100;
    localparam opc_t OPC_LUI    = 5'b01101;
    localparam opc_t OPC_BRANCH = 5'b11000;
    localparam opc_t OPC_JALR   = 5'b11001;
    localparam opc_t OPC_JAL    = 5'b11011;
    localparam opc_t OPC_SYSTEM = 5'b11100;

    // bits 1..0 of a non-compressed encoding
    localparam logic [1:0] OPC_FULL = 2'b11;

    function automatic logic is_full(input word_t w);
        return (w[1:0] == OPC_FULL);
    endfunction

    function automatic opc_t opc_of(input word_t w);
        return w[6:2];
    endfunction

    function automatic reg_idx_t rd_of(input word_t w);
        return w[11:7];
    endfunction

    function automatic reg_idx_t rs1_of(input word_t w);
        return w[19:15];
    endfunction

    function automatic reg_idx_t rs2_of(input word_t w);
        return w[24:20];
    endfunction

    function automatic funct3_t funct3_of(input word_t w);
        return w[14:12];
    endfunction

    function automatic funct7_t funct7_of(input word_t w);
        return w[31:25];
    endfunction

endpackage

/* src/rv_fetch_latch.sv */
`timescale 1ns/1ns

module rv_fetch_latch
#(
    parameter int IADDR_BITS = 16
)
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_stall,
    input  logic                    i_flush,
    input  logic                    i_ready,
    input  rv_decode_pkg::word_t    i_instruction,
    input  logic [IADDR_BITS-1:1]   i_pc,
    input  logic [IADDR_BITS-1:1]   i_pc_next,
    output rv_decode_pkg::word_t    o_instr,
    output logic                    o_valid,
    output logic [IADDR_BITS-1:1]   o_pc,
    output logic [IADDR_BITS-1:1]   o_pc_next
);
    import rv_decode_pkg::*;

    logic kill;
    logic load;

    // flush wins over stall
    assign kill = i_reset | i_flush;
    assign load = !kill & !i_stall;

    always_ff @(posedge i_clk)
    begin
        if (kill)
        begin
            o_instr <= '0;
            o_valid <= 1'b0;
        end
        else if (!i_stall)
        begin
            // a slot without ready becomes a bubble
            o_instr <= i_ready ? i_instruction : word_t'(0);
            o_valid <= i_ready;
        end
    end

    // pc travels with the word but is never cleared
    always_ff @(posedge i_clk)
    begin
        if (load)
        begin
            o_pc      <= i_pc;
            o_pc_next <= i_pc_next;
        end
    end

endmodule

/* src/rv_imm_gen.sv */
`timescale 1ns/1ns

module rv_imm_gen
(
    input  rv_decode_pkg::word_t i_instr,
    output rv_decode_pkg::word_t o_imm
);
    import rv_decode_pkg::*;

    opc_t  op;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign op = opc_of(i_instr);

    // all formats sign-extend from bit 31
    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb
    begin
        case (op)
            OPC_LUI,
            OPC_AUIPC:  o_imm = imm_u;
            OPC_JAL:    o_imm = imm_j;
            OPC_STORE:  o_imm = imm_s;
            OPC_BRANCH: o_imm = imm_b;
            // loads, op-imm, jalr and system
            default:    o_imm = imm_i;
        endcase
    end

endmodule

/* src/rv_op_classify.sv */
`timescale 1ns/1ns

module rv_op_classify
#(
    parameter logic EXT_M = 1'b1
)
(
    input  rv_decode_pkg::word_t    i_instr,
    input  logic                    i_valid,
    input  logic                    i_sys_supported,
    output rv_decode_pkg::reg_idx_t o_rd,
    output rv_decode_pkg::reg_idx_t o_rs1,
    output rv_decode_pkg::reg_idx_t o_rs2,
    output rv_decode_pkg::funct3_t  o_funct3,
    output logic                    o_reg_write,
    output logic                    o_op1_src_pc,
    output logic                    o_op2_src_imm,
    output logic                    o_res_mem,
    output logic                    o_res_pc_next,
    output logic                    o_res_alu,
    output logic                    o_inst_jal,
    output logic                    o_inst_jalr,
    output logic                    o_inst_branch,
    output logic                    o_inst_store,
    output logic                    o_inst_supported
);
    import rv_decode_pkg::*;

    opc_t    op;
    funct3_t funct3;
    funct7_t funct7;
    logic    full;
    logic    grp_load, grp_op_imm, grp_auipc, grp_store, grp_op;
    logic    grp_lui, grp_branch, grp_jalr, grp_jal;
    logic    shift_ok, op_imm_ok, op_ok, base_ok;
    logic    res_mem, res_pc_next;

    assign op     = opc_of(i_instr);
    assign funct3 = funct3_of(i_instr);
    assign funct7 = funct7_of(i_instr);
    assign full   = is_full(i_instr);

    // opcode groups, full encodings only
    assign grp_load   = full & (op == OPC_LOAD);
    assign grp_op_imm = full & (op == OPC_OP_IMM);
    assign grp_auipc  = full & (op == OPC_AUIPC);
    assign grp_store  = full & (op == OPC_STORE);
    assign grp_op     = full & (op == OPC_OP);
    assign grp_lui    = full & (op == OPC_LUI);
    assign grp_branch = full & (op == OPC_BRANCH);
    assign grp_jalr   = full & (op == OPC_JALR);
    assign grp_jal    = full & (op == OPC_JAL);

    assign o_rd     = rd_of(i_instr);
    assign o_rs1    = grp_lui ? reg_idx_t'(0) : rs1_of(i_instr);
    assign o_rs2    = rs2_of(i_instr);
    assign o_funct3 = funct3;

    assign o_reg_write   = full & !(grp_store | grp_branch);
    assign o_op1_src_pc  = grp_auipc | grp_jal;
    assign o_op2_src_imm = !(grp_op | grp_branch);

    assign res_mem       = grp_load;
    assign res_pc_next   = grp_jal | grp_jalr;
    assign o_res_mem     = res_mem;
    assign o_res_pc_next = res_pc_next;
    assign o_res_alu     = !(res_mem | res_pc_next);

    assign o_inst_jal    = grp_jal;
    assign o_inst_jalr   = grp_jalr;
    assign o_inst_branch = grp_branch;
    assign o_inst_store  = grp_store;

    // slli wants funct7 zero, srli/srai allow bit 5
    assign shift_ok  = (funct7 == 7'b0000000) | ((funct7 == 7'b0100000) & funct3[2]);
    assign op_imm_ok = grp_op_imm & ((funct3[1:0] != 2'b01) | shift_ok);
    assign op_ok     = grp_op & (!funct7[0] | EXT_M);
    assign base_ok   = grp_load | grp_store | grp_lui | grp_auipc | grp_branch |
                       grp_jal | (grp_jalr & (funct3 == 3'b000));

    // an empty slot never traps
    assign o_inst_supported = !i_valid | base_ok | op_imm_ok | op_ok | i_sys_supported;

endmodule

/* src/rv_alu_ctrl_gen.sv */
`timescale 1ns/1ns

module rv_alu_ctrl_gen
#(
    parameter logic EXT_M = 1'b1
)
(
    input  rv_decode_pkg::word_t i_instr,
    output logic                 o_alu_add_override,
    output logic                 o_alu_op2_inverse,
    output logic                 o_alu_sh_ar,
    output logic                 o_alu_group_mux,
    output logic                 o_alu_div_mux
);
    import rv_decode_pkg::*;

    opc_t    op;
    funct3_t funct3;
    funct7_t funct7;
    logic    add_ovr, mul_op, force_inv, no_inv;

    assign op     = opc_of(i_instr);
    assign funct3 = funct3_of(i_instr);
    assign funct7 = funct7_of(i_instr);

    // address and pc arithmetic always adds
    assign add_ovr = (op == OPC_LOAD) | (op == OPC_STORE) | (op == OPC_AUIPC) |
                     (op == OPC_LUI) | (op == OPC_JAL) | (op == OPC_JALR);
    assign mul_op  = (op == OPC_OP) & funct7[0] & EXT_M;

    // compare paths subtract
    assign force_inv = (op == OPC_BRANCH) |
                       ((op == OPC_OP_IMM) & (funct3[2:1] == 2'b01)) |
                       ((op == OPC_OP) & (funct3[2:1] == 2'b01) & !mul_op);
    assign no_inv    = add_ovr | (op == OPC_OP_IMM);

    assign o_alu_add_override = add_ovr;
    assign o_alu_op2_inverse  = force_inv ? 1'b1 : (no_inv ? 1'b0 : funct7[5]);
    assign o_alu_sh_ar        = funct7[5];
    assign o_alu_group_mux    = mul_op;
    assign o_alu_div_mux      = mul_op & funct3[2];

endmodule

/* src/rv_csr_decode.sv */
`timescale 1ns/1ns

module rv_csr_decode
#(
    parameter logic EXT_ZICSR = 1'b1
)
(
    input  rv_decode_pkg::word_t     i_instr,
    output rv_decode_pkg::csr_idx_t  o_csr_idx,
    output rv_decode_pkg::reg_idx_t  o_csr_imm,
    output logic                     o_csr_imm_sel,
    output logic                     o_csr_write,
    output logic                     o_csr_set,
    output logic                     o_csr_clear,
    output logic                     o_csr_read,
    output logic                     o_csr_ebreak,
    output logic                     o_inst_mret,
    output logic                     o_inst_csr_req,
    output logic                     o_sys_supported
);
    import rv_decode_pkg::*;

    funct3_t  funct3;
    funct7_t  funct7;
    reg_idx_t rs2;
    logic     sys, csr_acc, trap;
    logic     ecall, ebreak, mret, csr_req;

    assign funct3 = funct3_of(i_instr);
    assign funct7 = funct7_of(i_instr);
    assign rs2    = rs2_of(i_instr);

    assign sys     = is_full(i_instr) & (opc_of(i_instr) == OPC_SYSTEM);
    assign csr_acc = sys & (funct3 != 3'b000);
    assign trap    = sys & (funct3 == 3'b000);

    // bit 20 splits ecall from ebreak; mret has funct7 bit 3 set
    assign ecall   = trap & !funct7[3] & !rs2[0];
    assign ebreak  = trap & !funct7[3] & rs2[0];
    assign mret    = trap & funct7[4] & (rs2[2:1] == 2'b01) & EXT_ZICSR;
    assign csr_req = csr_acc & EXT_ZICSR;

    assign o_csr_idx     = i_instr[31:20];
    // uimm sits in the rs1 field
    assign o_csr_imm     = rs1_of(i_instr);
    assign o_csr_imm_sel = csr_acc & funct3[2];
    assign o_csr_write   = csr_acc & (funct3[1:0] == 2'b01);
    assign o_csr_set     = csr_acc & (funct3[1:0] == 2'b10);
    assign o_csr_clear   = csr_acc & (funct3[1:0] == 2'b11);
    assign o_csr_read    = csr_acc;
    assign o_csr_ebreak  = ebreak;

    assign o_inst_mret     = mret;
    assign o_inst_csr_req  = csr_req;
    assign o_sys_supported = ecall | ebreak | csr_req | mret;

endmodule

/* src/rv_decode_top.sv */
`timescale 1ns/1ns

module rv_decode_top
#(
    parameter int   IADDR_BITS = 16,
    parameter logic EXT_M      = 1'b1,
    parameter logic EXT_ZICSR  = 1'b1
)
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic                        i_ready,
    input  rv_decode_pkg::word_t        i_instruction,
    input  logic [IADDR_BITS-1:1]       i_pc,
    input  logic [IADDR_BITS-1:1]       i_pc_next,
    output logic [IADDR_BITS-1:1]       o_pc,
    output logic [IADDR_BITS-1:1]       o_pc_next,
    output rv_decode_pkg::reg_idx_t     o_rd,
    output rv_decode_pkg::reg_idx_t     o_rs1,
    output rv_decode_pkg::reg_idx_t     o_rs2,
    output rv_decode_pkg::word_t        o_imm,
    output rv_decode_pkg::funct3_t      o_funct3,
    output logic                        o_alu_add_override,
    output logic                        o_alu_op2_inverse,
    output logic                        o_alu_sh_ar,
    output logic                        o_alu_group_mux,
    output logic                        o_alu_div_mux,
    output logic                        o_res_mem,
    output logic                        o_res_pc_next,
    output logic                        o_res_alu,
    output logic                        o_reg_write,
    output logic                        o_op1_src_pc,
    output logic                        o_op2_src_imm,
    output logic                        o_inst_jal,
    output logic                        o_inst_jalr,
    output logic                        o_inst_branch,
    output logic                        o_inst_store,
    output logic                        o_inst_mret,
    output logic                        o_inst_csr_req,
    output logic                        o_inst_supported,
    output rv_decode_pkg::csr_idx_t     o_csr_idx,
    output rv_decode_pkg::reg_idx_t     o_csr_imm,
    output logic                        o_csr_imm_sel,
    output logic                        o_csr_write,
    output logic                        o_csr_set,
    output logic                        o_csr_clear,
    output logic                        o_csr_read,
    output logic                        o_csr_ebreak
);
    import rv_decode_pkg::*;

    word_t instr;
    logic  valid;
    logic  sys_supported;

    rv_fetch_latch
    #(
        .IADDR_BITS         (IADDR_BITS)
    )
    u_latch
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_stall            (i_stall),
        .i_flush            (i_flush),
        .i_ready            (i_ready),
        .i_instruction      (i_instruction),
        .i_pc               (i_pc),
        .i_pc_next          (i_pc_next),
        .o_instr            (instr),
        .o_valid            (valid),
        .o_pc               (o_pc),
        .o_pc_next          (o_pc_next)
    );

    rv_imm_gen
    u_imm
    (
        .i_instr            (instr),
        .o_imm              (o_imm)
    );

    rv_op_classify
    #(
        .EXT_M              (EXT_M)
    )
    u_classify
    (
        .i_instr            (instr),
        .i_valid            (valid),
        .i_sys_supported    (sys_supported),
        .o_rd               (o_rd),
        .o_rs1              (o_rs1),
        .o_rs2              (o_rs2),
        .o_funct3           (o_funct3),
        .o_reg_write        (o_reg_write),
        .o_op1_src_pc       (o_op1_src_pc),
        .o_op2_src_imm      (o_op2_src_imm),
        .o_res_mem          (o_res_mem),
        .o_res_pc_next      (o_res_pc_next),
        .o_res_alu          (o_res_alu),
        .o_inst_jal         (o_inst_jal),
        .o_inst_jalr        (o_inst_jalr),
        .o_inst_branch      (o_inst_branch),
        .o_inst_store       (o_inst_store),
        .o_inst_supported   (o_inst_supported)
    );

    rv_alu_ctrl_gen
    #(
        .EXT_M              (EXT_M)
    )
    u_alu_ctrl
    (
        .i_instr            (instr),
        .o_alu_add_override (o_alu_add_override),
        .o_alu_op2_inverse  (o_alu_op2_inverse),
        .o_alu_sh_ar        (o_alu_sh_ar),
        .o_alu_group_mux    (o_alu_group_mux),
        .o_alu_div_mux      (o_alu_div_mux)
    );

    rv_csr_decode
    #(
        .EXT_ZICSR          (EXT_ZICSR)
    )
    u_csr
    (
        .i_instr            (instr),
        .o_csr_idx          (o_csr_idx),
        .o_csr_imm          (o_csr_imm),
        .o_csr_imm_sel      (o_csr_imm_sel),
        .o_csr_write        (o_csr_write),
        .o_csr_set          (o_csr_set),
        .o_csr_clear        (o_csr_clear),
        .o_csr_read         (o_csr_read),
        .o_csr_ebreak       (o_csr_ebreak),
        .o_inst_mret        (o_inst_mret),
        .o_inst_csr_req     (o_inst_csr_req),
        .o_sys_supported    (sys_supported)
    );

endmodule

/* tests/tb_rv_decode.sv */
`timescale 1ns/1ns

module tb_rv_decode;

    localparam int N_OP      = 48;
    localparam int N_MEM     = 56;
    localparam int N_UNSUP   = 24;
    // reset cycles, the random tests and the fixed sequences of the other tests
    localparam int N_VECTORS = 10 + N_OP + N_MEM + N_UNSUP + 64;
    localparam int CLK_NS    = 20;

    logic        i_clk;
    logic        i_reset;
    logic        i_stall;
    logic        i_flush;
    logic        i_ready;
    logic [31:0] i_instruction;
    logic [15:1] i_pc;
    logic [15:1] i_pc_next;

    logic [15:1] o_pc, o_pc_next;
    logic [4:0]  o_rd, o_rs1, o_rs2, o_csr_imm;
    logic [31:0] o_imm;
    logic [2:0]  o_funct3;
    logic [11:0] o_csr_idx;
    logic        o_alu_add_override, o_alu_op2_inverse, o_alu_sh_ar;
    logic        o_alu_group_mux, o_alu_div_mux;
    logic        o_res_mem, o_res_pc_next, o_res_alu;
    logic        o_reg_write, o_op1_src_pc, o_op2_src_imm;
    logic        o_inst_jal, o_inst_jalr, o_inst_branch, o_inst_store;
    logic        o_inst_mret, o_inst_csr_req, o_inst_supported;
    logic        o_csr_imm_sel, o_csr_write, o_csr_set, o_csr_clear;
    logic        o_csr_read, o_csr_ebreak;

    // reference copy of the stage register
    logic [31:0] m_word;
    logic        m_valid;
    logic [15:1] m_pc, m_pc_next;

    logic [17:0] e_regs;
    logic [31:0] e_imm;
    logic [4:0]  e_alu;
    logic [12:0] e_ctrl;
    logic [22:0] e_csr;

    string test_name;
    int    n_checks = 0;
    int    n_errors = 0;
    int    n_pass = 0;
    int    n_fail = 0;
    int    start_checks;
    int    start_errors;

    rv_decode_top dut0 (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_NS / 2) i_clk = ~i_clk;
    end

    initial
    begin
        #(N_VECTORS * CLK_NS * 4);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    always @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            m_word  <= 32'h0;
            m_valid <= 1'b0;
        end
        else if (!i_stall)
        begin
            m_word    <= i_ready ? i_instruction : 32'h0;
            m_valid   <= i_ready;
            m_pc      <= i_pc;
            m_pc_next <= i_pc_next;
        end
    end

    task automatic ref_decode(input logic [31:0] w, input logic v);
        logic [4:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        logic full, ld, opi, aui, st, opr, lui, br, jalr, jal;
        logic sys, csr, trap, ecall, ebreak, mret;
        logic add, mul, inv, shamt_ok, ok;
        begin
            op   = w[6:2];
            f3   = w[14:12];
            f7   = w[31:25];
            full = (w[1:0] == 2'b11);
            ld   = full && (op == 5'b00000);
            opi  = full && (op == 5'b00100);
            aui  = full && (op == 5'b00101);
            st   = full && (op == 5'b01000);
            opr  = full && (op == 5'b01100);
            lui  = full && (op == 5'b01101);
            br   = full && (op == 5'b11000);
            jalr = full && (op == 5'b11001);
            jal  = full && (op == 5'b11011);
            sys  = full && (op == 5'b11100);
            e_regs = {w[11:7], lui ? 5'd0 : w[19:15], w[24:20], f3};
            case (op)
                5'b01101, 5'b00101: e_imm = {w[31:12], 12'h000};
                5'b11011: e_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                5'b01000: e_imm = {{21{w[31]}}, w[30:25], w[11:7]};
                5'b11000: e_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                default:  e_imm = {{21{w[31]}}, w[30:20]};
            endcase
            // alu fields look at the opcode bits only
            add = (op == 5'b00000) || (op == 5'b01000) || (op == 5'b00101) ||
                  (op == 5'b01101) || (op == 5'b11011) || (op == 5'b11001);
            mul = (op == 5'b01100) && f7[0];
            if ((op == 5'b11000) || ((op == 5'b00100) && (f3[2:1] == 2'b01)) ||
                ((op == 5'b01100) && !mul && (f3[2:1] == 2'b01)))
                inv = 1'b1;
            else if (add || (op == 5'b00100))
                inv = 1'b0;
            else
                inv = f7[5];
            e_alu = {add, inv, f7[5], mul, mul && f3[2]};
            csr    = sys && (f3 != 3'b000);
            trap   = sys && (f3 == 3'b000);
            ecall  = trap && (w[31:20] == 12'h000);
            ebreak = trap && (w[31:20] == 12'h001);
            mret   = trap && (w[31:20] == 12'h302);
            if (f3 == 3'b001)
                shamt_ok = (f7 == 7'h00);
            else if (f3 == 3'b101)
                shamt_ok = (f7 == 7'h00) || (f7 == 7'h20);
            else
                shamt_ok = 1'b1;
            ok = !v || ld || st || lui || aui || br || jal || (jalr && (f3 == 3'b000)) ||
                 (opi && shamt_ok) || opr || ecall || ebreak || csr || mret;
            e_ctrl = {ld, jal || jalr, !(ld || jal || jalr), full && !(st || br),
                      aui || jal, !(opr || br), jal, jalr, br, st, mret, csr, ok};
            e_csr = {w[31:20], w[19:15], csr && f3[2], csr && (f3[1:0] == 2'b01),
                     csr && (f3[1:0] == 2'b10), csr && (f3[1:0] == 2'b11), csr, ebreak};
        end
    endtask

    task automatic compare(input string field, input logic [63:0] exp, input logic [63:0] act);
        begin
            n_checks++;
            assert (exp === act)
            else
            begin
                $display("** Error %s: %s expected %0h, actual %0h", test_name, field, exp, act);
                n_errors++;
            end
        end
    endtask

    task automatic check_outputs;
        begin
            ref_decode(m_word, m_valid);
            compare("regs", e_regs, {o_rd, o_rs1, o_rs2, o_funct3});
            compare("imm", e_imm, o_imm);
            compare("alu", e_alu, {o_alu_add_override, o_alu_op2_inverse, o_alu_sh_ar,
                                   o_alu_group_mux, o_alu_div_mux});
            compare("ctrl", e_ctrl, {o_res_mem, o_res_pc_next, o_res_alu, o_reg_write,
                                     o_op1_src_pc, o_op2_src_imm, o_inst_jal, o_inst_jalr,
                                     o_inst_branch, o_inst_store, o_inst_mret,
                                     o_inst_csr_req, o_inst_supported});
            compare("csr", e_csr, {o_csr_idx, o_csr_imm, o_csr_imm_sel, o_csr_write,
                                   o_csr_set, o_csr_clear, o_csr_read, o_csr_ebreak});
            if (m_valid)
                compare("pc", {m_pc, m_pc_next}, {o_pc, o_pc_next});
        end
    endtask

    // check the previous decode, then present the next slot
    task automatic step(input logic [31:0] w, input logic rdy, input logic stl, input logic fls);
        logic [31:0] r;
        begin
            @(negedge i_clk);
            check_outputs();
            r = $urandom;
            i_instruction = w;
            i_ready = rdy;
            i_stall = stl;
            i_flush = fls;
            i_pc = r[15:1];
            i_pc_next = r[15:1] + 15'd2;
        end
    endtask

    function automatic logic [31:0] rand_word(input logic [6:0] low);
        logic [31:0] w;
        w = $urandom;
        w[6:0] = low;
        return w;
    endfunction

    function automatic logic [6:0] pick_funct7();
        case ($urandom % 3)
            0:       return 7'h00;
            1:       return 7'h20;
            default: return 7'h01;
        endcase
    endfunction

    task automatic begin_test(input string name);
        begin
            test_name = name;
            start_checks = n_checks;
            start_errors = n_errors;
        end
    endtask

    task automatic end_test;
        begin
            step(32'h0, 1'b0, 1'b0, 1'b0);
            if (n_errors == start_errors)
                n_pass++;
            else
                n_fail++;
            $display("test %s: %0d checks, %0d errors", test_name,
                     n_checks - start_checks, n_errors - start_errors);
        end
    endtask

    initial
    begin
        int          i;
        int          k;
        logic [31:0] w;
        logic [31:0] r;
        r = $urandom(18);
        i_reset = 1'b1;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_ready = 1'b0;
        i_instruction = 32'h0;
        i_pc = '0;
        i_pc_next = '0;
        repeat (10) @(posedge i_clk);

        begin_test("reset_flush");
        step(32'h0, 1'b0, 1'b0, 1'b0);
        i_reset = 1'b0;
        step(rand_word(7'b0110011), 1'b1, 1'b0, 1'b0);
        // flush during a stall still clears the slot
        step(rand_word(7'b1101111), 1'b1, 1'b1, 1'b1);
        step(32'h0, 1'b0, 1'b0, 1'b0);
        end_test();

        begin_test("register_ops");
        for (i = 0; i < N_OP; i++)
        begin
            w = rand_word((i % 2) ? 7'b0110011 : 7'b0010011);
            if ($urandom % 4 != 0)
                w[31:25] = pick_funct7();
            step(w, 1'b1, 1'b0, 1'b0);
        end
        end_test();

        begin_test("imm_flags");
        for (i = 0; i < N_MEM; i++)
        begin
            case (i % 7)
                0:       w = rand_word(7'b0000011);
                1:       w = rand_word(7'b0100011);
                2:       w = rand_word(7'b1100011);
                3:       w = rand_word(7'b0110111);
                4:       w = rand_word(7'b0010111);
                5:       w = rand_word(7'b1101111);
                default: w = rand_word(7'b1100111);
            endcase
            step(w, 1'b1, 1'b0, 1'b0);
        end
        end_test();

        begin_test("stall_ready");
        step(rand_word(7'b0110011), 1'b1, 1'b0, 1'b0);
        repeat (3) step(rand_word(7'b0010011), 1'b1, 1'b1, 1'b0);
        step(rand_word(7'b0000011), 1'b0, 1'b0, 1'b0);
        step(rand_word(7'b1101111), 1'b1, 1'b0, 1'b0);
        step(rand_word(7'b0110111), 1'b0, 1'b1, 1'b0);
        step(rand_word(7'b0100011), 1'b0, 1'b0, 1'b0);
        end_test();

        begin_test("system");
        for (i = 0; i < 12; i++)
        begin
            k = i % 6;
            r = (k < 3) ? k + 1 : k + 2;
            w = rand_word(7'b1110011);
            w[14:12] = r[2:0];
            step(w, 1'b1, 1'b0, 1'b0);
        end
        step(32'h00000073, 1'b1, 1'b0, 1'b0);
        step(32'h00100073, 1'b1, 1'b0, 1'b0);
        step(32'h30200073, 1'b1, 1'b0, 1'b0);
        end_test();

        begin_test("unsupported");
        for (i = 0; i < N_UNSUP; i++)
        begin
            case (i % 6)
                0: w = rand_word(7'b0000111);
                1: w = rand_word(7'b0100111);
                2: w = rand_word(7'b1010011);
                3: w = rand_word(7'b1000011);
                4: w = rand_word(7'b0001111);
                default:
                begin
                    // compressed-looking word with bits 1..0 not 11
                    w = $urandom;
                    r = $urandom % 3;
                    w[1:0] = r[1:0];
                end
            endcase
            step(w, 1'b1, 1'b0, 1'b0);
        end
        end_test();

        $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 n_pass, n_fail, n_checks, n_errors);
        if (n_errors == 0 && n_fail == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* build.f */
src/rv_decode_pkg.sv
src/rv_fetch_latch.sv
src/rv_imm_gen.sv
src/rv_op_classify.sv
src/rv_alu_ctrl_gen.sv
src/rv_csr_decode.sv
src/rv_decode_top.sv
tests/tb_rv_decode.sv
